// ==== vlog.f ====
cnn_types_pkg.sv
cnn_map_pkg.sv
feature_mem_if.sv
cnn_bus_ctrl.sv
input_store.sv
feature_mem.sv
conv_layer.sv
maxpool_layer.sv
cnn_top.sv
tb_clock.sv
cnn_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cnn testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cnn_tb -f vlog.f -o cnn_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/cnn_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "TEST PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== cnn_tb.sv ====
`timescale 1ns/1ps
module cnn_tb
	import cnn_map_pkg::*;
();
	localparam int IMG_SIZE = 8;
	localparam int CONV_SIZE = IMG_SIZE - 2;
	localparam int POOL_SIZE = CONV_SIZE / 2;
	localparam int RESET_CYCLES = 10;
	localparam int RESET_TIMEOUT = 100;
	localparam int IRQ_TIMEOUT = 20000;
	localparam logic [31:0] SEED_INIT = 32'h591c;

	logic clk;
	logic rst;
	bus_addr_t awaddr;
	logic awvalid;
	logic [31:0] wdata;
	logic wvalid;
	bus_addr_t araddr;
	logic arvalid;
	logic [31:0] rdata;
	logic interrupt;
	logic clr_write;

	// software copy of what the DUT should hold
	int pix [IMG_SIZE * IMG_SIZE];
	int wt [9];
	int bias_val;
	int expected [POOL_SIZE * POOL_SIZE];
	integer seed;

	tb_clock #(.RESET_CYCLES(RESET_CYCLES)) clock_gen (
		.clk(clk),
		.rst(rst)
	);

	cnn_top #(.IMG_SIZE(IMG_SIZE)) dut0 (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arvalid(arvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.rdata(rdata),
		.interrupt(interrupt)
	);

	assign clr_write = awvalid && wvalid && (awaddr == IRQ_CLR_ADDR);

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_equal(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		assert (act_val == exp_val)
		else
			fail_run($sformatf("[ERROR] time %0t: %s expected %0h, actual %0h",
				$time, name, exp_val, act_val));
	endtask

	// interrupt is a level that only a clear write drops
	a_irq_holds: assert property (@(posedge clk) disable iff (rst)
		interrupt && !clr_write |=> interrupt)
	else
		fail_run($sformatf("[ERROR] time %0t: interrupt expected 1, actual 0", $time));

	a_irq_clears: assert property (@(posedge clk) disable iff (rst)
		clr_write |=> !interrupt)
	else
		fail_run($sformatf("[ERROR] time %0t: interrupt expected 0, actual 1", $time));

	// all bus tasks start and end just after a falling edge
	task automatic write_word(input bus_addr_t addr, input logic [31:0] data);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic read_word(input bus_addr_t addr, output logic [31:0] data);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		arvalid = 1'b0;
		// rdata lands two edges after the request
		@(negedge clk);
		data = rdata;
	endtask

	task automatic set_pixels(input bit use_random, input int value);
		int i;
		for (i = 0; i < IMG_SIZE * IMG_SIZE; i++)
		begin
			if (use_random)
				pix[i] = $random(seed) & 32'hff;
			else
				pix[i] = value;
			write_word(PIXEL_BASE + bus_addr_t'(4 * i), 32'(pix[i]));
		end
	endtask

	task automatic set_weights(input bit use_random, input int value);
		int k;
		for (k = 0; k < 9; k++)
		begin
			if (use_random)
				wt[k] = $random(seed) % 128;
			else
				wt[k] = value;
			write_word(WEIGHT_BASE + bus_addr_t'(4 * k), 32'(wt[k]));
		end
	endtask

	task automatic set_bias(input int value);
		bias_val = value;
		write_word(BIAS_ADDR, 32'(value));
	endtask

	function automatic int conv_value(input int r, input int c);
		int sum;
		int kr;
		int kc;
		sum = bias_val;
		for (kr = 0; kr < 3; kr++)
		begin
			for (kc = 0; kc < 3; kc++)
				sum += pix[(r + kr) * IMG_SIZE + c + kc] * wt[kr * 3 + kc];
		end
		// relu, then saturate at 16 bits
		if (sum < 0)
			sum = 0;
		else if (sum > 65535)
			sum = 65535;
		return sum;
	endfunction

	task automatic compute_model();
		int pr;
		int pc;
		int dr;
		int dc;
		int best;
		int v;
		for (pr = 0; pr < POOL_SIZE; pr++)
		begin
			for (pc = 0; pc < POOL_SIZE; pc++)
			begin
				best = 0;
				for (dr = 0; dr < 2; dr++)
				begin
					for (dc = 0; dc < 2; dc++)
					begin
						v = conv_value(2 * pr + dr, 2 * pc + dc);
						if (v > best)
							best = v;
					end
				end
				expected[pr * POOL_SIZE + pc] = best;
			end
		end
	endtask

	task automatic wait_for_irq();
		int cycles;
		cycles = 0;
		while (!interrupt && cycles < IRQ_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!interrupt)
			fail_run("interrupt did not rise within 20000 cycles after start");
	endtask

	task automatic check_results(input bit const_check, input int const_value);
		logic [31:0] val;
		int j;
		for (j = 0; j < POOL_SIZE * POOL_SIZE; j++)
		begin
			read_word(RESULT_BASE + bus_addr_t'(4 * j), val);
			check_equal($sformatf("rdata result %0d", j), 32'(expected[j]), val);
			if (const_check)
				check_equal($sformatf("rdata result %0d", j), 32'(const_value), val);
		end
	endtask

	initial
	begin
		logic [31:0] val;
		int cycles;
		int i;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		seed = SEED_INIT;

		cycles = 0;
		while (rst && cycles < RESET_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (rst)
			fail_run("reset never deasserted");
		@(negedge clk);

		// state right after reset
		check_equal("interrupt", 32'h0, 32'(interrupt));
		check_equal("rdata", 32'h0, rdata);
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h0, val);

		// bias alone far below zero
		set_pixels(1'b1, 0);
		set_weights(1'b0, 0);
		set_bias(-32768);
		compute_model();
		write_word(CTRL_ADDR, 32'h1);
		wait_for_irq();
		check_results(1'b1, 0);
		write_word(IRQ_CLR_ADDR, 32'h0);

		// every window saturates
		set_pixels(1'b0, 255);
		set_weights(1'b0, 127);
		set_bias(100);
		compute_model();
		write_word(CTRL_ADDR, 32'h1);
		wait_for_irq();
		check_results(1'b1, 65535);
		write_word(IRQ_CLR_ADDR, 32'h0);

		// random image and kernel
		set_pixels(1'b1, 0);
		set_weights(1'b1, 0);
		set_bias($random(seed) % 256);
		compute_model();
		write_word(CTRL_ADDR, 32'h1);
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h1, val);
		wait_for_irq();
		check_results(1'b0, 0);

		// level holds until cleared
		for (i = 0; i < 50; i++)
		begin
			@(negedge clk);
			check_equal("interrupt", 32'h1, 32'(interrupt));
		end
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h2, val);
		write_word(IRQ_CLR_ADDR, 32'h0);
		check_equal("interrupt", 32'h0, 32'(interrupt));
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h0, val);

		// new pixels, kernel and bias kept from the last run
		set_pixels(1'b1, 0);
		write_word(32'h5000_0000, 32'hffff_ffff);
		write_word(WEIGHT_BASE + 32'd36, 32'h7f);
		write_word(BIAS_ADDR + 32'd4, 32'h1234);
		write_word(PIXEL_BASE + bus_addr_t'(4 * IMG_SIZE * IMG_SIZE), 32'hff);
		// bit 0 low leaves the engine idle
		write_word(CTRL_ADDR, 32'h0);
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h0, val);
		compute_model();
		write_word(CTRL_ADDR, 32'h1);
		// all dropped while busy
		write_word(PIXEL_BASE, 32'hab);
		write_word(WEIGHT_BASE + 32'd16, 32'h55);
		write_word(BIAS_ADDR, 32'h7fff);
		write_word(CTRL_ADDR, 32'h1);
		read_word(STATUS_ADDR, val);
		check_equal("status", 32'h1, val);
		wait_for_irq();
		check_results(1'b0, 0);
		read_word(32'h5000_0000, val);
		check_equal("rdata unmapped", 32'h0, val);

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps
module tb_clock
#(
	parameter int RESET_CYCLES = 10
)
(
	output logic clk,
	output logic rst
);
	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== cnn_top.sv ====
`timescale 1ns/1ps
module cnn_top
	import cnn_types_pkg::*;
	import cnn_map_pkg::*;
#(
	parameter int IMG_SIZE = 8
)
(
	input logic clk,
	input logic rst,
	input bus_addr_t araddr,
	input logic arvalid,
	input logic [31:0] wdata,
	input logic wvalid,
	input bus_addr_t awaddr,
	input logic awvalid,
	output logic [31:0] rdata,
	output logic interrupt
);
	localparam int CONV_SIZE = IMG_SIZE - 2;
	localparam int POOL_SIZE = CONV_SIZE / 2;

	logic start;
	logic conv_done;
	logic pool_done;
	logic pixel_we;
	logic weight_we;
	logic bias_we;
	logic [2*$bits(coord_t)-1:0] load_index;
	logic [15:0] load_data;
	coord_t pixel_row;
	coord_t pixel_col;
	pixel_t pixel_data;
	weight_t [8:0] weights;
	bias_t bias;

	// conv output map, then pooled map
	feature_mem_if conv_fm ();
	feature_mem_if pool_fm ();

	cnn_bus_ctrl #(.IMG_SIZE(IMG_SIZE)) ctrl (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.wdata(wdata),
		.wvalid(wvalid),
		.araddr(araddr),
		.arvalid(arvalid),
		.pool_done(pool_done),
		.rdata(rdata),
		.interrupt(interrupt),
		.start(start),
		.pixel_we(pixel_we),
		.weight_we(weight_we),
		.bias_we(bias_we),
		.load_index(load_index),
		.load_data(load_data),
		.res(pool_fm)
	);

	input_store #(.IMG_SIZE(IMG_SIZE)) in_store (
		.clk(clk),
		.rst(rst),
		.pixel_we(pixel_we),
		.weight_we(weight_we),
		.bias_we(bias_we),
		.load_index(load_index),
		.load_data(load_data),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.pixel_data(pixel_data),
		.weights(weights),
		.bias(bias)
	);

	conv_layer #(.IMG_SIZE(IMG_SIZE)) conv (
		.clk(clk),
		.rst(rst),
		.start(start),
		.pixel_data(pixel_data),
		.weights(weights),
		.bias(bias),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.conv_done(conv_done),
		.out(conv_fm)
	);

	feature_mem #(.SIZE(CONV_SIZE)) conv_mem (
		.clk(clk),
		.rst(rst),
		.mem(conv_fm)
	);

	maxpool_layer #(.IN_SIZE(CONV_SIZE)) pool (
		.clk(clk),
		.rst(rst),
		.start(conv_done),
		.pool_done(pool_done),
		.src(conv_fm),
		.dst(pool_fm)
	);

	feature_mem #(.SIZE(POOL_SIZE)) pool_mem (
		.clk(clk),
		.rst(rst),
		.mem(pool_fm)
	);

endmodule

// ==== maxpool_layer.sv ====
`timescale 1ns/1ps
module maxpool_layer
	import cnn_types_pkg::*;
#(
	parameter int IN_SIZE = 6
)
(
	input logic clk,
	input logic rst,
	input logic start,
	output logic pool_done,
	feature_mem_if.reader src,
	feature_mem_if.writer dst
);
	typedef enum logic [1:0] {st_idle, st_read, st_drain, st_store} pool_state_t;

	// odd trailing row and column drop out here
	localparam coord_t LAST_POS = coord_t'(IN_SIZE / 2 - 1);

	pool_state_t state;
	coord_t prow;
	coord_t pcol;
	logic [1:0] tap;
	feature_t maxv;
	logic last_pos;

	always_comb
	begin
		last_pos = (prow == LAST_POS) && (pcol == LAST_POS);
		src.rd_en = (state == st_read);
		src.rd_row = (prow << 1) + coord_t'(tap[1]);
		src.rd_col = (pcol << 1) + coord_t'(tap[0]);
		dst.save_en = (state == st_store);
		dst.save_row = prow;
		dst.save_col = pcol;
		dst.save_data = maxv;
	end

	// rd_data trails the request by one cycle
	always_ff @(posedge clk)
	begin
		if (state == st_read && tap == 2'd1)
			maxv <= src.rd_data;
		else if ((state == st_read && tap != 2'd0) || state == st_drain)
		begin
			if (src.rd_data > maxv)
				maxv <= src.rd_data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			prow <= '0;
			pcol <= '0;
			tap <= '0;
			pool_done <= 1'b0;
		end
		else
		begin
			pool_done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
					begin
						prow <= '0;
						pcol <= '0;
						tap <= '0;
						state <= st_read;
					end
				end
				st_read:
				begin
					tap <= tap + 2'd1;
					if (tap == 2'd3)
						state <= st_drain;
				end
				st_drain: state <= st_store;
				st_store:
				begin
					tap <= '0;
					if (last_pos)
					begin
						pool_done <= 1'b1;
						state <= st_idle;
					end
					else
					begin
						if (pcol == LAST_POS)
						begin
							pcol <= '0;
							prow <= prow + 8'd1;
						end
						else
							pcol <= pcol + 8'd1;
						state <= st_read;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== conv_layer.sv ====
`timescale 1ns/1ps
module conv_layer
	import cnn_types_pkg::*;
#(
	parameter int IMG_SIZE = 8
)
(
	input logic clk,
	input logic rst,
	input logic start,
	input pixel_t pixel_data,
	input weight_t [8:0] weights,
	input bias_t bias,
	output coord_t pixel_row,
	output coord_t pixel_col,
	output logic conv_done,
	feature_mem_if.writer out
);
	typedef enum logic [1:0] {st_idle, st_fetch, st_accumulate, st_store} conv_state_t;

	// last valid output row and column
	localparam coord_t LAST_POS = coord_t'(IMG_SIZE - 3);

	conv_state_t state;
	coord_t orow;
	coord_t ocol;
	logic [1:0] kr;
	logic [1:0] kc;
	logic [1:0] kr_n;
	logic [1:0] kc_n;
	logic last_tap;
	logic last_pos;
	logic [3:0] widx;
	weight_t w_cur;
	logic signed [16:0] prod;
	acc_t acc;

	always_comb
	begin
		last_tap = (kr == 2'd2) && (kc == 2'd2);
		last_pos = (orow == LAST_POS) && (ocol == LAST_POS);
		kc_n = (kc == 2'd2) ? 2'd0 : kc + 2'd1;
		kr_n = (kc == 2'd2) ? kr + 2'd1 : kr;
		widx = {2'b00, kr} * 4'd3 + {2'b00, kc};
		w_cur = weights[widx];
		// pixels are unsigned, widen before the signed multiply
		prod = $signed({1'b0, pixel_data}) * w_cur;
	end

	// address runs one tap ahead of the data
	always_comb
	begin
		if (state == st_accumulate && !last_tap)
		begin
			pixel_row = orow + coord_t'(kr_n);
			pixel_col = ocol + coord_t'(kc_n);
		end
		else
		begin
			pixel_row = orow;
			pixel_col = ocol;
		end
	end

	// relu then saturate to 16 bits
	always_comb
	begin
		if (acc < 0)
			out.save_data = '0;
		else if (acc > 24'sd65535)
			out.save_data = '1;
		else
			out.save_data = feature_t'(acc);
		out.save_en = (state == st_store);
		out.save_row = orow;
		out.save_col = ocol;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			orow <= '0;
			ocol <= '0;
			kr <= '0;
			kc <= '0;
			conv_done <= 1'b0;
		end
		else
		begin
			conv_done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (start)
					begin
						orow <= '0;
						ocol <= '0;
						state <= st_fetch;
					end
				end
				st_fetch:
				begin
					kr <= '0;
					kc <= '0;
					state <= st_accumulate;
				end
				st_accumulate:
				begin
					kr <= kr_n;
					kc <= kc_n;
					if (last_tap)
						state <= st_store;
				end
				st_store:
				begin
					if (last_pos)
					begin
						conv_done <= 1'b1;
						state <= st_idle;
					end
					else
					begin
						if (ocol == LAST_POS)
						begin
							ocol <= '0;
							orow <= orow + 8'd1;
						end
						else
							ocol <= ocol + 8'd1;
						state <= st_fetch;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_fetch)
			acc <= acc_t'(bias);
		else if (state == st_accumulate)
			acc <= acc + acc_t'(prod);
	end

endmodule

// ==== feature_mem.sv ====
`timescale 1ns/1ps
module feature_mem
	import cnn_types_pkg::*;
#(
	parameter int SIZE = 6
)
(
	input logic clk,
	input logic rst,
	feature_mem_if.mem mem
);
	localparam int DEPTH = SIZE * SIZE;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam coord_t DIM = coord_t'(SIZE);

	feature_t store [DEPTH];
	logic [AW-1:0] waddr;
	logic [AW-1:0] raddr;

	// row-major flattening
	always_comb
	begin
		waddr = AW'(mem.save_row * SIZE + mem.save_col);
		raddr = AW'(mem.rd_row * SIZE + mem.rd_col);
	end

	always_ff @(posedge clk)
	begin
		if (mem.save_en)
			store[waddr] <= mem.save_data;
	end

	// read word holds until the next request
	always_ff @(posedge clk)
	begin
		if (rst)
			mem.rd_data <= '0;
		else if (mem.rd_en)
			mem.rd_data <= store[raddr];
	end

	a_save_in_range: assert property (@(posedge clk) disable iff (rst)
		mem.save_en |-> (mem.save_row < DIM) && (mem.save_col < DIM));

	a_read_in_range: assert property (@(posedge clk) disable iff (rst)
		mem.rd_en |-> (mem.rd_row < DIM) && (mem.rd_col < DIM));

endmodule

// ==== input_store.sv ====
`timescale 1ns/1ps
module input_store
	import cnn_types_pkg::*;
#(
	parameter int IMG_SIZE = 8
)
(
	input logic clk,
	input logic rst,
	input logic pixel_we,
	input logic weight_we,
	input logic bias_we,
	input logic [2*$bits(coord_t)-1:0] load_index,
	input logic [15:0] load_data,
	input coord_t pixel_row,
	input coord_t pixel_col,
	output pixel_t pixel_data,
	output weight_t [8:0] weights,
	output bias_t bias
);
	localparam int PIX_N = IMG_SIZE * IMG_SIZE;
	localparam int PIX_W = $clog2(PIX_N);
	localparam logic [15:0] PIX_LIMIT = 16'(PIX_N);

	pixel_t pix_mem [PIX_N];
	logic [PIX_W-1:0] rd_idx;

	assign rd_idx = PIX_W'(pixel_row * IMG_SIZE + pixel_col);

	always_ff @(posedge clk)
	begin
		if (pixel_we)
			pix_mem[load_index[PIX_W-1:0]] <= load_data[7:0];
		pixel_data <= pix_mem[rd_idx];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			weights <= '0;
			bias <= '0;
		end
		else
		begin
			if (weight_we)
				weights[load_index[3:0]] <= weight_t'(load_data[7:0]);
			if (bias_we)
				bias <= bias_t'(load_data);
		end
	end

	// the bus decoder only forwards in-range pixel writes
	a_pixel_index: assert property (@(posedge clk) disable iff (rst)
		pixel_we |-> load_index < PIX_LIMIT);

endmodule

// ==== cnn_bus_ctrl.sv ====
`timescale 1ns/1ps
module cnn_bus_ctrl
	import cnn_types_pkg::*;
	import cnn_map_pkg::*;
#(
	parameter int IMG_SIZE = 8
)
(
	input logic clk,
	input logic rst,
	input bus_addr_t awaddr,
	input logic awvalid,
	input logic [31:0] wdata,
	input logic wvalid,
	input bus_addr_t araddr,
	input logic arvalid,
	input logic pool_done,
	output logic [31:0] rdata,
	output logic interrupt,
	output logic start,
	output logic pixel_we,
	output logic weight_we,
	output logic bias_we,
	output logic [2*$bits(coord_t)-1:0] load_index,
	output logic [15:0] load_data,
	feature_mem_if.reader res
);
	localparam int RES_SIZE = (IMG_SIZE - 2) / 2;
	localparam bus_addr_t PIXEL_END = PIXEL_BASE + bus_addr_t'(4 * IMG_SIZE * IMG_SIZE);
	localparam bus_addr_t WEIGHT_END = WEIGHT_BASE + bus_addr_t'(4 * 9);
	localparam bus_addr_t RESULT_END = RESULT_BASE + bus_addr_t'(4 * RES_SIZE * RES_SIZE);
	localparam logic [15:0] RES_DIM = 16'(RES_SIZE);

	logic wr;
	logic pixel_hit;
	logic weight_hit;
	logic bias_hit;
	logic ctrl_hit;
	logic clr_hit;
	logic res_hit;
	logic status_hit;
	logic start_set;
	logic busy;
	logic [15:0] res_idx;
	logic [31:0] status_word;
	logic [31:0] status_q;
	logic rd_v;
	logic rd_status;
	logic rd_result;

	always_comb
	begin
		wr = awvalid && wvalid;
		pixel_hit = (awaddr >= PIXEL_BASE) && (awaddr < PIXEL_END) && (awaddr[1:0] == 2'b00);
		weight_hit = (awaddr >= WEIGHT_BASE) && (awaddr < WEIGHT_END) && (awaddr[1:0] == 2'b00);
		bias_hit = (awaddr == BIAS_ADDR);
		ctrl_hit = (awaddr == CTRL_ADDR);
		clr_hit = (awaddr == IRQ_CLR_ADDR);
		start_set = wr && ctrl_hit && wdata[0] && !busy;
	end

	// all bases are 256MB aligned, so word index is just the low address bits
	always_comb
	begin
		res_hit = (araddr >= RESULT_BASE) && (araddr < RESULT_END) && (araddr[1:0] == 2'b00);
		status_hit = (araddr == STATUS_ADDR);
		res_idx = araddr[17:2];
		res.rd_en = arvalid && res_hit;
		res.rd_row = coord_t'(res_idx / RES_DIM);
		res.rd_col = coord_t'(res_idx % RES_DIM);
		status_word = '0;
		status_word[STATUS_BUSY_BIT] = busy;
		status_word[STATUS_IRQ_BIT] = interrupt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			interrupt <= 1'b0;
			start <= 1'b0;
			pixel_we <= 1'b0;
			weight_we <= 1'b0;
			bias_we <= 1'b0;
		end
		else
		begin
			start <= start_set;
			pixel_we <= wr && pixel_hit && !busy;
			weight_we <= wr && weight_hit && !busy;
			bias_we <= wr && bias_hit && !busy;
			if (start_set)
				busy <= 1'b1;
			else if (pool_done)
				busy <= 1'b0;
			// completion wins over a clear in the same cycle
			if (pool_done)
				interrupt <= 1'b1;
			else if (wr && clr_hit)
				interrupt <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			load_index <= awaddr[17:2];
			load_data <= wdata[15:0];
		end
		if (arvalid)
			status_q <= status_word;
	end

	// stage 1 waits on the feature memory and stage 2 muxes into rdata
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_v <= 1'b0;
			rd_status <= 1'b0;
			rd_result <= 1'b0;
			rdata <= '0;
		end
		else
		begin
			rd_v <= arvalid;
			rd_status <= arvalid && status_hit;
			rd_result <= arvalid && res_hit;
			if (rd_v)
			begin
				if (rd_result)
					rdata <= 32'(res.rd_data);
				else if (rd_status)
					rdata <= status_q;
				else
					rdata <= '0;
			end
		end
	end

	// pooling can only finish inside a run that start opened
	a_done_while_busy: assert property (@(posedge clk) disable iff (rst)
		pool_done |-> busy);

endmodule

// ==== feature_mem_if.sv ====
`timescale 1ns/1ps
interface feature_mem_if
	import cnn_types_pkg::*;
();
	// write side, owned by the producing layer
	logic save_en;
	coord_t save_row;
	coord_t save_col;
	feature_t save_data;

	// read side, owned by the consumer
	logic rd_en;
	coord_t rd_row;
	coord_t rd_col;
	feature_t rd_data;

	modport writer (output save_en, output save_row, output save_col, output save_data);

	modport reader (output rd_en, output rd_row, output rd_col, input rd_data);

	modport mem (
		input save_en,
		input save_row,
		input save_col,
		input save_data,
		input rd_en,
		input rd_row,
		input rd_col,
		output rd_data
	);
endinterface

// ==== cnn_map_pkg.sv ====
package cnn_map_pkg;

	typedef logic [31:0] bus_addr_t;

	// word per pixel, row-major
	localparam bus_addr_t PIXEL_BASE = 32'h1000_0000;

	// word per weight, row-major kernel order
	localparam bus_addr_t WEIGHT_BASE = 32'h2000_0000;

	localparam bus_addr_t BIAS_ADDR = 32'h3000_0000;

	// bit 0 of wdata starts a run
	localparam bus_addr_t CTRL_ADDR = 32'h4000_0000;
	localparam bus_addr_t IRQ_CLR_ADDR = 32'h4000_0004;
	localparam bus_addr_t STATUS_ADDR = 32'h4000_0008;

	// pooled map, row-major
	localparam bus_addr_t RESULT_BASE = 32'hd000_0000;

	// status word layout
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_IRQ_BIT = 1;

endpackage

// ==== cnn_types_pkg.sv ====
package cnn_types_pkg;

	// raw image pixel
	typedef logic [7:0] pixel_t;

	// kernel weight
	typedef logic signed [7:0] weight_t;

	typedef logic signed [15:0] bias_t;

	// nine 17-bit products plus bias fit with room to spare
	typedef logic signed [23:0] acc_t;

	// activation after relu, saturated at 16 bits
	typedef logic [15:0] feature_t;

	// row or column index into any map
	typedef logic [7:0] coord_t;

endpackage
